// File: verilog/rd_guard_pkg.sv
// Widths, channel and table layouts shared by the read-channel watchdog
// Modules pull these in with a wildcard import
package rd_guard_pkg;

  localparam int unsigned IdWidth       = 4;
  localparam int unsigned LenWidth      = 8;
  localparam int unsigned CntWidth      = 10;
  localparam int unsigned LdIdxMaxWidth = 4;

  typedef logic [IdWidth-1:0]       id_t;
  typedef logic [LenWidth-1:0]      len_t;
  typedef logic [CntWidth-1:0]      cnt_t;
  typedef logic [LdIdxMaxWidth-1:0] ld_idx_t;
  typedef logic [LdIdxMaxWidth-1:0] ht_idx_t;

  typedef struct packed {
    id_t  id;
    len_t len;
  } ar_chan_t;

  typedef struct packed {
    id_t  id;
    logic last;
  } r_chan_t;

  typedef struct packed {
    cnt_t cnt_arvalid_arready;
    cnt_t cnt_arvalid_rfirst;
    cnt_t cnt_rvalid_rready_first;
    cnt_t cnt_rfirst_rlast;
  } counters_t;

  typedef enum logic [1:0] {
    READ_IDLE,
    READ_ADDRESS,
    READ_DATA
  } read_state_e;

  typedef struct packed {
    id_t         id;
    len_t        len;
    read_state_e read_state;
    counters_t   counters;
    cnt_t        r1_budget;
    cnt_t        r3_budget;
    ld_idx_t     next;
    logic        free;
  } linked_data_t;

  typedef struct packed {
    id_t     id;
    ld_idx_t head;
    ld_idx_t tail;
    logic    free;
  } head_tail_t;

  // Empty table slots
  localparam linked_data_t LdFree = '{read_state: READ_IDLE, free: 1'b1, default: '0};
  localparam head_tail_t   HtFree = '{free: 1'b1, default: '0};

  typedef struct packed {
    logic    ar_new;
    logic    ar_accept;
    logic    r_first;
    logic    r_beat;
    logic    r_last;
    logic    id_exists;
    logic    no_in_id_match;
    ht_idx_t match_in_idx;
    ht_idx_t rsp_idx;
    ht_idx_t head_tail_free_idx;
    ld_idx_t linked_data_free_idx;
    logic    full;
  } rd_events_t;

  typedef struct packed {
    cnt_t budget_arvld_arrdy;
    cnt_t budget_rvld_rrdy;
    cnt_t accum_burst_length;
  } budgets_t;

  typedef struct packed {
    logic r0;
    logic r1;
    logic r2;
    logic r3;
    logic unwanted;
  } cause_t;

  typedef struct packed {
    cause_t    cause;
    id_t       txn_id;
    counters_t lat;
  } guard_status_t;

endpackage

// File: verilog/rd_id_lookup.sv
// Turns bus handshakes into single-cycle events and searches the tables
// for free slots and for the lists that belong to the AR and R IDs
`timescale 1ns/10ps

module rd_id_lookup #(
  parameter int unsigned MaxRdTxns  = 4,
  parameter int unsigned HtCapacity = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      ar_valid_i,
  input  logic                                      ar_ready_i,
  input  rd_guard_pkg::ar_chan_t                    ar_i,
  input  logic                                      r_valid_i,
  input  logic                                      r_ready_i,
  input  rd_guard_pkg::r_chan_t                     r_i,
  input  rd_guard_pkg::head_tail_t [HtCapacity-1:0] head_tail_i,
  input  rd_guard_pkg::linked_data_t [MaxRdTxns-1:0] linked_data_i,
  output rd_guard_pkg::rd_events_t                  events_o
);
  import rd_guard_pkg::*;

  logic                  ar_pend_q;
  logic [2**IdWidth-1:0] burst_q;
  logic                  ar_accept;
  logic                  r_beat;
  logic                  ht_found;
  logic                  ld_found;

  assign ar_accept = ar_valid_i && ar_ready_i;
  assign r_beat    = r_valid_i && r_ready_i;

  always_comb begin
    events_o                = '0;
    events_o.ar_new         = ar_valid_i && !ar_pend_q;
    events_o.ar_accept      = ar_accept;
    events_o.r_first        = r_valid_i && !burst_q[r_i.id];
    events_o.r_beat         = r_beat;
    events_o.r_last         = r_beat && r_i.last;
    events_o.no_in_id_match = 1'b1;
    ht_found                = 1'b0;
    ld_found                = 1'b0;
    // Scan downwards so the lowest index wins
    for (int i = HtCapacity - 1; i >= 0; i--) begin
      if (head_tail_i[i].free) begin
        ht_found                    = 1'b1;
        events_o.head_tail_free_idx = ht_idx_t'(i);
      end else begin
        if (head_tail_i[i].id == ar_i.id) begin
          events_o.no_in_id_match = 1'b0;
          events_o.match_in_idx   = ht_idx_t'(i);
        end
        if (head_tail_i[i].id == r_i.id) begin
          events_o.id_exists = 1'b1;
          events_o.rsp_idx   = ht_idx_t'(i);
        end
      end
    end
    for (int i = MaxRdTxns - 1; i >= 0; i--) begin
      if (linked_data_i[i].free) begin
        ld_found                      = 1'b1;
        events_o.linked_data_free_idx = ld_idx_t'(i);
      end
    end
    events_o.full = !ld_found || (events_o.no_in_id_match && !ht_found);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ar_pend_q <= 1'b0;
      burst_q   <= '0;
    end else begin
      ar_pend_q <= ar_valid_i && !ar_accept;
      // Burst stays open until its last beat
      if (r_beat) begin
        burst_q[r_i.id] <= !r_i.last;
      end
    end
  end

endmodule

// File: verilog/rd_txn_manager.sv
// Next-state logic for the per-ID read lists: enqueue, phase change,
// budget checks, in-order completion and flush on a violation
`timescale 1ns/10ps

module rd_txn_manager #(
  parameter int unsigned MaxRdTxns  = 4,
  parameter int unsigned HtCapacity = 4
) (
  input  rd_guard_pkg::rd_events_t                   events_i,
  input  rd_guard_pkg::ar_chan_t                     ar_i,
  input  rd_guard_pkg::budgets_t                     budgets_i,
  input  rd_guard_pkg::head_tail_t [HtCapacity-1:0]  head_tail_q_i,
  input  rd_guard_pkg::linked_data_t [MaxRdTxns-1:0] linked_data_q_i,
  output rd_guard_pkg::head_tail_t [HtCapacity-1:0]  head_tail_d_o,
  output rd_guard_pkg::linked_data_t [MaxRdTxns-1:0] linked_data_d_o,
  output logic                                       timeout_o,
  output logic                                       reset_req_o,
  output rd_guard_pkg::cause_t                       cause_o,
  output rd_guard_pkg::id_t                          txn_id_o,
  output logic                                       lat_valid_o,
  output rd_guard_pkg::counters_t                    lat_o
);
  import rd_guard_pkg::*;

  cnt_t         r1_budget;
  cnt_t         r3_budget;
  ld_idx_t      head_idx;
  ld_idx_t      tail_idx;
  ld_idx_t      free_idx;
  linked_data_t head_entry;
  ht_idx_t      open_idx;
  logic         open_list;

  // First R may take the accumulated budget plus one cycle per beat
  assign r1_budget  = budgets_i.accum_burst_length + cnt_t'(ar_i.len);
  assign r3_budget  = cnt_t'(ar_i.len) + cnt_t'(1);
  assign head_idx   = head_tail_q_i[events_i.rsp_idx].head;
  assign tail_idx   = head_tail_q_i[events_i.match_in_idx].tail;
  assign free_idx   = events_i.linked_data_free_idx;
  assign head_entry = linked_data_q_i[head_idx];

  always_comb begin
    head_tail_d_o   = head_tail_q_i;
    linked_data_d_o = linked_data_q_i;
    cause_o         = '0;
    txn_id_o        = '0;
    lat_valid_o     = 1'b0;
    lat_o           = head_entry.counters;
    open_list       = 1'b0;
    open_idx        = events_i.head_tail_free_idx;

    for (int i = 0; i < MaxRdTxns; i++) begin
      if (!linked_data_q_i[i].free) begin
        case (linked_data_q_i[i].read_state)
          READ_ADDRESS: begin
            if (linked_data_q_i[i].counters.cnt_arvalid_arready >
                budgets_i.budget_arvld_arrdy) begin
              cause_o.r0 = 1'b1;
              txn_id_o   = linked_data_q_i[i].id;
            end
            if (linked_data_q_i[i].counters.cnt_arvalid_rfirst >
                linked_data_q_i[i].r1_budget) begin
              cause_o.r1 = 1'b1;
              txn_id_o   = linked_data_q_i[i].id;
            end
          end
          READ_DATA: begin
            if (linked_data_q_i[i].counters.cnt_rvalid_rready_first >
                budgets_i.budget_rvld_rrdy) begin
              cause_o.r2 = 1'b1;
              txn_id_o   = linked_data_q_i[i].id;
            end
            // Too many beats for the announced length
            if (linked_data_q_i[i].counters.cnt_rfirst_rlast >
                linked_data_q_i[i].r3_budget) begin
              cause_o.r3 = 1'b1;
              txn_id_o   = linked_data_q_i[i].id;
            end
          end
          default: ;
        endcase
      end
    end

    // Only the oldest read of an ID can see its first beat
    if (events_i.r_first && events_i.id_exists &&
        (head_entry.read_state == READ_ADDRESS)) begin
      linked_data_d_o[head_idx].read_state = READ_DATA;
    end

    if (events_i.r_last) begin
      if (events_i.id_exists) begin
        lat_valid_o               = 1'b1;
        linked_data_d_o[head_idx] = LdFree;
        if (head_idx == head_tail_q_i[events_i.rsp_idx].tail) begin
          head_tail_d_o[events_i.rsp_idx] = HtFree;
        end else begin
          head_tail_d_o[events_i.rsp_idx].head = head_entry.next;
        end
      end else begin
        cause_o.unwanted = 1'b1;
      end
    end

    if (events_i.ar_new && !events_i.full) begin
      if (events_i.no_in_id_match) begin
        open_list = 1'b1;
      end else if (head_tail_d_o[events_i.match_in_idx].free) begin
        // List drained this very cycle, reuse its slot
        open_list = 1'b1;
        open_idx  = events_i.match_in_idx;
      end
      if (open_list) begin
        head_tail_d_o[open_idx] = '{
          id:   ar_i.id,
          head: free_idx,
          tail: free_idx,
          free: 1'b0
        };
      end else begin
        linked_data_d_o[tail_idx].next            = free_idx;
        head_tail_d_o[events_i.match_in_idx].tail = free_idx;
      end
      linked_data_d_o[free_idx] = '{
        id:         ar_i.id,
        len:        ar_i.len,
        read_state: READ_ADDRESS,
        counters:   '0,
        r1_budget:  r1_budget,
        r3_budget:  r3_budget,
        next:       '0,
        free:       1'b0
      };
    end

    timeout_o   = cause_o.r0 | cause_o.r1 | cause_o.r2 | cause_o.r3;
    reset_req_o = cause_o.r0 | cause_o.r1 | cause_o.r3 | cause_o.unwanted;

    if (timeout_o || reset_req_o) begin
      linked_data_d_o = {MaxRdTxns{LdFree}};
      head_tail_d_o   = {HtCapacity{HtFree}};
    end
  end

endmodule

// File: verilog/rd_txn_store.sv
// Table registers of the watchdog; every live read ages its latency
// counters here on the way into the flops
`timescale 1ns/10ps

module rd_txn_store #(
  parameter int unsigned MaxRdTxns  = 4,
  parameter int unsigned HtCapacity = 4
) (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic                                       ar_ready_i,
  input  logic                                       r_valid_i,
  input  logic                                       r_ready_i,
  input  rd_guard_pkg::head_tail_t [HtCapacity-1:0]  head_tail_d_i,
  input  rd_guard_pkg::linked_data_t [MaxRdTxns-1:0] linked_data_d_i,
  output rd_guard_pkg::head_tail_t [HtCapacity-1:0]  head_tail_q_o,
  output rd_guard_pkg::linked_data_t [MaxRdTxns-1:0] linked_data_q_o
);
  import rd_guard_pkg::*;

  linked_data_t [MaxRdTxns-1:0] ld_aged;

  function automatic cnt_t sat_inc(cnt_t value);
    return (value == '1) ? value : value + cnt_t'(1);
  endfunction

  always_comb begin
    counters_t c;
    ld_aged = linked_data_d_i;
    for (int i = 0; i < MaxRdTxns; i++) begin
      c = linked_data_d_i[i].counters;
      if (!linked_data_d_i[i].free) begin
        if (linked_data_d_i[i].read_state == READ_ADDRESS) begin
          // Equal counts mean AR ready has not been seen yet
          if (!ar_ready_i && (c.cnt_arvalid_arready == c.cnt_arvalid_rfirst)) begin
            ld_aged[i].counters.cnt_arvalid_arready = sat_inc(c.cnt_arvalid_arready);
          end
          ld_aged[i].counters.cnt_arvalid_rfirst = sat_inc(c.cnt_arvalid_rfirst);
        end
        if (linked_data_d_i[i].read_state == READ_DATA) begin
          // First beat stalled
          if (r_valid_i && !r_ready_i && (c.cnt_rfirst_rlast == '0)) begin
            ld_aged[i].counters.cnt_rvalid_rready_first =
              sat_inc(c.cnt_rvalid_rready_first);
          end
          if (r_valid_i && r_ready_i) begin
            ld_aged[i].counters.cnt_rfirst_rlast = sat_inc(c.cnt_rfirst_rlast);
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_tail_q_o   <= {HtCapacity{HtFree}};
      linked_data_q_o <= {MaxRdTxns{LdFree}};
    end else begin
      head_tail_q_o   <= head_tail_d_i;
      linked_data_q_o <= ld_aged;
    end
  end

endmodule

// File: verilog/rd_guard_regs.sv
// Sticky interrupt status and latency capture, cleared by clear_i
`timescale 1ns/10ps

module rd_guard_regs (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        clear_i,
  input  logic                        timeout_i,
  input  logic                        reset_req_i,
  input  rd_guard_pkg::cause_t        cause_i,
  input  rd_guard_pkg::id_t           txn_id_i,
  input  logic                        lat_valid_i,
  input  rd_guard_pkg::counters_t     lat_i,
  output logic                        irq_o,
  output logic                        reset_req_o,
  output rd_guard_pkg::guard_status_t status_o
);
  import rd_guard_pkg::*;

  guard_status_t status_d;
  logic          req_prev_q;

  always_comb begin
    status_d = status_o;
    if (clear_i) begin
      status_d = '0;
    end else begin
      // Keep the ID of the first timeout only
      if (timeout_i && !(|status_o.cause)) begin
        status_d.txn_id = txn_id_i;
      end
      status_d.cause = status_o.cause | cause_i;
      if (lat_valid_i) begin
        status_d.lat = lat_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      status_o    <= '0;
      irq_o       <= 1'b0;
      reset_req_o <= 1'b0;
      req_prev_q  <= 1'b0;
    end else begin
      status_o    <= status_d;
      irq_o       <= |status_d.cause;
      reset_req_o <= reset_req_i && !req_prev_q;
      req_prev_q  <= reset_req_i;
    end
  end

endmodule

// File: verilog/rd_guard_top.sv
// Read-channel watchdog top, snoops AR and R of one manager port
// Budgets are static levels, clear_i acknowledges a latched interrupt
`timescale 1ns/10ps

module rd_guard_top #(
  parameter int unsigned MaxRdTxns  = 4,
  parameter int unsigned HtCapacity = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      ar_valid_i,
  input  logic                      ar_ready_i,
  input  rd_guard_pkg::ar_chan_t    ar_i,
  input  logic                      r_valid_i,
  input  logic                      r_ready_i,
  input  rd_guard_pkg::r_chan_t     r_i,
  input  rd_guard_pkg::budgets_t    budgets_i,
  input  logic                      clear_i,
  output logic                      irq_o,
  output logic                      reset_req_o,
  output rd_guard_pkg::guard_status_t status_o
);
  import rd_guard_pkg::*;

  rd_events_t                   events;
  head_tail_t   [HtCapacity-1:0] head_tail_q;
  head_tail_t   [HtCapacity-1:0] head_tail_d;
  linked_data_t [MaxRdTxns-1:0]  linked_data_q;
  linked_data_t [MaxRdTxns-1:0]  linked_data_d;
  logic                         timeout;
  logic                         reset_req;
  cause_t                       cause;
  id_t                          txn_id;
  logic                         lat_valid;
  counters_t                    lat;

  rd_id_lookup #(
    .MaxRdTxns  (MaxRdTxns),
    .HtCapacity (HtCapacity)
  ) i_rd_id_lookup (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ar_valid_i    (ar_valid_i),
    .ar_ready_i    (ar_ready_i),
    .ar_i          (ar_i),
    .r_valid_i     (r_valid_i),
    .r_ready_i     (r_ready_i),
    .r_i           (r_i),
    .head_tail_i   (head_tail_q),
    .linked_data_i (linked_data_q),
    .events_o      (events)
  );

  rd_txn_manager #(
    .MaxRdTxns  (MaxRdTxns),
    .HtCapacity (HtCapacity)
  ) i_rd_txn_manager (
    .events_i        (events),
    .ar_i            (ar_i),
    .budgets_i       (budgets_i),
    .head_tail_q_i   (head_tail_q),
    .linked_data_q_i (linked_data_q),
    .head_tail_d_o   (head_tail_d),
    .linked_data_d_o (linked_data_d),
    .timeout_o       (timeout),
    .reset_req_o     (reset_req),
    .cause_o         (cause),
    .txn_id_o        (txn_id),
    .lat_valid_o     (lat_valid),
    .lat_o           (lat)
  );

  rd_txn_store #(
    .MaxRdTxns  (MaxRdTxns),
    .HtCapacity (HtCapacity)
  ) i_rd_txn_store (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .ar_ready_i      (ar_ready_i),
    .r_valid_i       (r_valid_i),
    .r_ready_i       (r_ready_i),
    .head_tail_d_i   (head_tail_d),
    .linked_data_d_i (linked_data_d),
    .head_tail_q_o   (head_tail_q),
    .linked_data_q_o (linked_data_q)
  );

  rd_guard_regs i_rd_guard_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear_i),
    .timeout_i   (timeout),
    .reset_req_i (reset_req),
    .cause_i     (cause),
    .txn_id_i    (txn_id),
    .lat_valid_i (lat_valid),
    .lat_i       (lat),
    .irq_o       (irq_o),
    .reset_req_o (reset_req_o),
    .status_o    (status_o)
  );

endmodule

// File: testbench/tb_rd_guard.sv
// Top-level simulation testbench for the read-channel watchdog
// Covers clean reads, same-ID order, each budget violation, unwanted responses and clear
`timescale 1ns/10ps

module tb_rd_guard;
  import rd_guard_pkg::*;

  localparam int unsigned NumReads       = 12;
  localparam int unsigned NumPairs       = 3;
  localparam int unsigned ReadCycles     = 40;
  localparam int unsigned WatchdogCycles =
    16 + (2 * NumReads + 2 * NumPairs) * ReadCycles + 6 * 60 + 200;

  logic          clk_i = 1'b0;
  logic          rst_n_i;
  logic          ar_valid_i;
  logic          ar_ready_i;
  ar_chan_t      ar_i;
  logic          r_valid_i;
  logic          r_ready_i;
  r_chan_t       r_i;
  budgets_t      budgets_i;
  logic          clear_i;
  logic          irq_o;
  logic          reset_req_o;
  guard_status_t status_o;

  int unsigned   rng_state = 32'h696a_488b;
  int            cyc = 0;
  int            req_pulses = 0;
  logic          req_seen = 1'b0;
  logic          clean_mode = 1'b0;
  counters_t     exp_q[$];

  rd_guard_top rd_guard_top_i (.*);

  always #10 clk_i = !clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  // Reset request must be a single-cycle pulse; clean traffic never interrupts
  always @(negedge clk_i) begin
    if (reset_req_o) begin
      assert (!req_seen) else begin
        $display("reset_req_o stayed high for more than one cycle");
        $display("TB FAILED");
        $fatal(1);
      end
      req_pulses++;
    end
    req_seen = reset_req_o;
    if (clean_mode) begin
      assert (!irq_o && !reset_req_o) else begin
        $display("ERROR irq_o 0x%0h reset_req_o 0x%0h expected 0x0", irq_o, reset_req_o);
        $display("TB FAILED");
        $fatal(1);
      end
    end
  end

  initial begin
    #(WatchdogCycles * 20);
    $display("Watchdog expired before the tests finished");
    $display("TB FAILED");
    $fatal(1);
  end

  function automatic int unsigned next_rand(input int unsigned range);
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x % range;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  function automatic counters_t make_exp(input int d, input int rfirst, input int s,
                                         input len_t len);
    counters_t c;
    c.cnt_arvalid_arready     = cnt_t'(d);
    c.cnt_arvalid_rfirst      = cnt_t'(rfirst);
    c.cnt_rvalid_rready_first = cnt_t'(s);
    c.cnt_rfirst_rlast        = cnt_t'(len);
    return c;
  endfunction

  function automatic logic [4:0] cause_bits(input logic r0, input logic r1, input logic r2,
                                            input logic r3, input logic unw);
    return {r0, r1, r2, r3, unw};
  endfunction

  // Oldest expected completion against the captured latencies
  task automatic check_completion();
    counters_t e;
    e = exp_q.pop_front();
    check_eq("status_o.lat.cnt_arvalid_arready", status_o.lat.cnt_arvalid_arready,
             e.cnt_arvalid_arready);
    check_eq("status_o.lat.cnt_arvalid_rfirst", status_o.lat.cnt_arvalid_rfirst,
             e.cnt_arvalid_rfirst);
    check_eq("status_o.lat.cnt_rvalid_rready_first", status_o.lat.cnt_rvalid_rready_first,
             e.cnt_rvalid_rready_first);
    check_eq("status_o.lat.cnt_rfirst_rlast", status_o.lat.cnt_rfirst_rlast,
             e.cnt_rfirst_rlast);
  endtask

  // AR ready comes d cycles after AR valid
  task automatic send_ar(input id_t id, input len_t len, input int d, output int start);
    start = cyc;
    ar_valid_i <= 1'b1;
    ar_i       <= '{id: id, len: len};
    ar_ready_i <= 1'b0;
    repeat (d) @(posedge clk_i);
    ar_ready_i <= 1'b1;
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
    ar_ready_i <= 1'b0;
  endtask

  // First beat stalls s cycles and later beats go back to back
  task automatic send_r(input id_t id, input int s, input int beats, input logic with_last,
                        output int start);
    start = cyc;
    r_valid_i <= 1'b1;
    r_i       <= '{id: id, last: with_last && (beats == 1)};
    r_ready_i <= 1'b0;
    repeat (s) @(posedge clk_i);
    r_ready_i <= 1'b1;
    for (int b = 1; b < beats; b++) begin
      @(posedge clk_i);
      r_i <= '{id: id, last: with_last && (b == beats - 1)};
    end
    @(posedge clk_i);
    r_valid_i <= 1'b0;
    r_ready_i <= 1'b0;
    r_i       <= '0;
  endtask

  task automatic run_single_read();
    id_t  id;
    len_t len;
    int   d;
    int   g;
    int   s;
    int   ar_t;
    int   r_t;
    id  = id_t'(next_rand(8));
    len = len_t'(next_rand(4));
    d   = next_rand(6);
    g   = next_rand(5);
    s   = next_rand(4);
    send_ar(id, len, d, ar_t);
    repeat (g) @(posedge clk_i);
    send_r(id, s, int'(len) + 1, 1'b1, r_t);
    exp_q.push_back(make_exp(d, r_t - ar_t, s, len));
    @(negedge clk_i);
    check_completion();
    @(posedge clk_i);
  endtask

  task automatic run_same_id_pair();
    id_t  id;
    len_t la;
    len_t lb;
    int   da;
    int   db;
    int   ta;
    int   tb;
    int   ra;
    int   rb;
    int   sa;
    int   sb;
    id = id_t'(next_rand(8));
    la = len_t'(next_rand(4));
    lb = len_t'(next_rand(4));
    da = next_rand(4);
    db = next_rand(4);
    sa = next_rand(3);
    sb = next_rand(3);
    send_ar(id, la, da, ta);
    send_ar(id, lb, db, tb);
    repeat (next_rand(4)) @(posedge clk_i);
    send_r(id, sa, int'(la) + 1, 1'b1, ra);
    exp_q.push_back(make_exp(da, ra - ta, sa, la));
    @(negedge clk_i);
    check_completion();
    @(posedge clk_i);
    send_r(id, sb, int'(lb) + 1, 1'b1, rb);
    exp_q.push_back(make_exp(db, rb - tb, sb, lb));
    @(negedge clk_i);
    check_completion();
    @(posedge clk_i);
  endtask

  // Returns once irq_o is high
  task automatic wait_irq(input int max_cycles);
    int n;
    n = 0;
    while (!irq_o && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (!irq_o) begin
      $display("irq_o did not rise within %0d cycles", max_cycles);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_violation(input logic [4:0] cause, input id_t id, input int pulses);
    repeat (3) @(negedge clk_i);
    check_eq("status_o.cause", status_o.cause, cause);
    check_eq("status_o.txn_id", status_o.txn_id, id);
    check_eq("reset_req_o pulses", req_pulses, pulses);
    @(posedge clk_i);
  endtask

  task automatic pulse_clear();
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(negedge clk_i);
    check_eq("irq_o", irq_o, 0);
    check_eq("status_o.cause", status_o.cause, 0);
    @(posedge clk_i);
  endtask

  initial begin
    int t;
    int pulses;
    rst_n_i    = 1'b0;
    ar_valid_i = 1'b0;
    ar_ready_i = 1'b0;
    ar_i       = '0;
    r_valid_i  = 1'b0;
    r_ready_i  = 1'b0;
    r_i        = '0;
    clear_i    = 1'b0;
    budgets_i  = '{budget_arvld_arrdy: 10'd12, budget_rvld_rrdy: 10'd12,
                   accum_burst_length: 10'd200};
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_eq("irq_o", irq_o, 0);
    check_eq("reset_req_o", reset_req_o, 0);
    check_eq("status_o", status_o, 0);
    @(posedge clk_i);

    clean_mode = 1'b1;
    repeat (NumReads) run_single_read();
    repeat (NumPairs) run_same_id_pair();
    clean_mode = 1'b0;

    // AR ready held low past its budget
    pulses = req_pulses + 1;
    ar_valid_i <= 1'b1;
    ar_i       <= '{id: 4'd3, len: 8'd1};
    wait_irq(40);
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
    check_violation(cause_bits(1, 0, 0, 0, 0), 4'd3, pulses);
    pulse_clear();

    // First beat later than accum plus len
    budgets_i.accum_burst_length <= 10'd10;
    @(posedge clk_i);
    pulses = req_pulses + 1;
    send_ar(4'd5, 8'd2, 0, t);
    wait_irq(40);
    @(posedge clk_i);
    budgets_i.accum_burst_length <= 10'd200;
    check_violation(cause_bits(0, 1, 0, 0, 0), 4'd5, pulses);
    pulse_clear();

    // Beats beyond len plus one; ID 15 stays out of the random range
    pulses = req_pulses + 1;
    send_ar(4'd15, 8'd1, 0, t);
    send_r(4'd15, 0, 6, 1'b0, t);
    wait_irq(10);
    @(posedge clk_i);
    check_violation(cause_bits(0, 0, 0, 1, 0), 4'd15, pulses);
    pulse_clear();

    // First beat ready stalled with no reset request expected
    pulses = req_pulses;
    send_ar(4'd6, 8'd0, 0, t);
    r_valid_i <= 1'b1;
    r_i       <= '{id: 4'd6, last: 1'b1};
    wait_irq(40);
    @(posedge clk_i);
    r_valid_i <= 1'b0;
    r_i       <= '0;
    check_violation(cause_bits(0, 0, 1, 0, 0), 4'd6, pulses);
    pulse_clear();

    // Last beat for an ID with nothing outstanding
    pulses = req_pulses + 1;
    send_r(4'd9, 0, 1, 1'b1, t);
    wait_irq(10);
    @(posedge clk_i);
    check_violation(cause_bits(0, 0, 0, 0, 1), 4'd0, pulses);
    pulse_clear();

    clean_mode = 1'b1;
    repeat (NumReads) run_single_read();
    clean_mode = 1'b0;

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: filelist.f
verilog/rd_guard_pkg.sv
verilog/rd_id_lookup.sv
verilog/rd_txn_manager.sv
verilog/rd_txn_store.sv
verilog/rd_guard_regs.sv
verilog/rd_guard_top.sv
testbench/tb_rd_guard.sv

// File: run_sim.sh
#!/bin/sh
# Builds the watchdog testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rd_guard \
  -f filelist.f \
  -o Vtb_rd_guard
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rd_guard > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -q "^TB PASSED$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
